// File: common/mm_consts.svh
/* Array and matrix sizes, set at compile time
   I_OUTER and W_OUTER must be multiples of BLOCK, INNER at least 2*BLOCK */
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

`define MM_WIDTH     16 // Q8.8 element
`define MM_FRAC      8
`define MM_BLOCK     2  // Array is BLOCK x BLOCK cells
`define MM_INNER     4  // Shared dimension
`define MM_I_OUTER   4  // Rows of A
`define MM_W_OUTER   4  // Columns of W

`define MM_ROW_TILES (`MM_I_OUTER / `MM_BLOCK)
`define MM_COL_TILES (`MM_W_OUTER / `MM_BLOCK)
`define MM_TILES     (`MM_ROW_TILES * `MM_COL_TILES)

// Full product plus growth over INNER terms
`define MM_ACC_WIDTH (2 * `MM_WIDTH + $clog2(`MM_INNER + 1))

// One buffer word per tile and k
`define MM_A_ADDR_W  $clog2(`MM_ROW_TILES * `MM_INNER)
`define MM_W_ADDR_W  $clog2(`MM_COL_TILES * `MM_INNER)

`endif

// File: common/mm_ctrl_pkg.sv
/* Control types shared by the sequencer and the array */
`include "mm_consts.svh"

package mm_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        STREAM, // One read request per cycle
        FLUSH   // Array draining, wait for the last tile
    } ctrl_state_e;

    typedef struct packed {
        logic valid;
        logic first; // k == 0
        logic last;  // k == INNER-1
    } feed_tag_t;

    // Tag rides along with the read latency
    typedef struct packed {
        logic [`MM_A_ADDR_W-1:0] a_addr;
        logic [`MM_W_ADDR_W-1:0] w_addr;
        feed_tag_t               tag;
    } rd_req_t;

endpackage

// File: common/mm_data_pkg.sv
/* Data types of the datapath
   Elements are signed Q8.8, the accumulator keeps the full-precision sum */
`include "mm_consts.svh"

package mm_data_pkg;

    typedef logic signed [`MM_WIDTH-1:0] elem_t;
    typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

    // One buffer word
    // A word at rowtile*INNER+k is column k of that row tile
    // W word at coltile*INNER+k is row k of that column tile
    typedef struct packed {
        elem_t [`MM_BLOCK-1:0] e; // e[0] is lane 0
    } op_vec_t;

    // One output row of a tile, already scaled and saturated
    typedef struct packed {
        elem_t [`MM_BLOCK-1:0] e; // e[j] is column j of the tile
    } res_row_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the matmul testbench with Verilator and run it
# Exit status is nonzero when the simulation ends in $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f verilog.f --top-module matmul_tb -o matmul_sim
./obj_dir/matmul_sim

// File: source/matmul_controller.sv
/* Tile sequencer, walks output tiles row-major and k inside each tile
   Requests go out back to back, start is ignored until the run is done */
`timescale 1ns/1ps
`include "mm_consts.svh"

module matmul_controller (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   done,  // From the drain, last row of last tile
    output logic                   busy,
    output mm_ctrl_pkg::rd_req_t   req,
    output mm_ctrl_pkg::feed_tag_t tag    // Lines up with buffer read data
);

    localparam int K_W  = (`MM_INNER > 1) ? $clog2(`MM_INNER) : 1;
    localparam int RT_W = (`MM_ROW_TILES > 1) ? $clog2(`MM_ROW_TILES) : 1;
    localparam int CT_W = (`MM_COL_TILES > 1) ? $clog2(`MM_COL_TILES) : 1;
    localparam int A_AW = `MM_A_ADDR_W;
    localparam int W_AW = `MM_W_ADDR_W;

    mm_ctrl_pkg::ctrl_state_e state;

    logic [K_W-1:0]  k;
    logic [CT_W-1:0] col_t;
    logic [RT_W-1:0] row_t;
    logic            last_k;
    logic            last_col;
    logic            last_row;
    logic            streaming;

    assign last_k    = (k == K_W'(`MM_INNER - 1));
    assign last_col  = (col_t == CT_W'(`MM_COL_TILES - 1));
    assign last_row  = (row_t == RT_W'(`MM_ROW_TILES - 1));
    assign streaming = (state == mm_ctrl_pkg::STREAM);
    assign busy      = (state != mm_ctrl_pkg::IDLE);

    // Request for the current slice
    always_comb begin
        req.a_addr    = A_AW'(row_t * `MM_INNER + k);
        req.w_addr    = W_AW'(col_t * `MM_INNER + k);
        req.tag.valid = streaming;
        req.tag.first = streaming && (k == '0);
        req.tag.last  = streaming && last_k;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mm_ctrl_pkg::IDLE;
            k     <= '0;
            col_t <= '0;
            row_t <= '0;
            tag   <= '0;
        end else begin
            tag <= req.tag; // One cycle, same as the RAM read
            case (state)
                mm_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= mm_ctrl_pkg::STREAM; // Counters already at zero
                    end
                end
                mm_ctrl_pkg::STREAM: begin
                    k <= last_k ? '0 : k + 1'b1;
                    if (last_k) begin // Tile fully issued
                        col_t <= last_col ? '0 : col_t + 1'b1;
                        if (last_col) begin
                            row_t <= last_row ? '0 : row_t + 1'b1;
                            if (last_row) begin
                                state <= mm_ctrl_pkg::FLUSH;
                            end
                        end
                    end
                end
                mm_ctrl_pkg::FLUSH: begin
                    if (done) begin
                        state <= mm_ctrl_pkg::IDLE;
                    end
                end
                default: state <= mm_ctrl_pkg::IDLE;
            endcase
        end
    end

    // A start while busy must not restart the walk at tile 0
    a_start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        (start && busy) |=> !(streaming && k == '0 && col_t == '0 && row_t == '0));

endmodule

// File: source/matmul_top.sv
/* Tiled Q8.8 matrix multiplier, C = A x W on a BLOCK x BLOCK systolic array
   Buffers must be loaded before start, rows come out with no back-pressure */
`timescale 1ns/1ps
`include "mm_consts.svh"

module matmul_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          a_wr,
    input  logic [`MM_A_ADDR_W-1:0]       a_addr,
    input  mm_data_pkg::op_vec_t          a_data,
    input  logic                          w_wr,
    input  logic [`MM_W_ADDR_W-1:0]       w_addr,
    input  mm_data_pkg::op_vec_t          w_data,
    input  logic                          start,
    output logic                          busy,
    output logic                          res_valid,
    output mm_data_pkg::res_row_t         res,
    output logic                          done
);

    localparam int B = `MM_BLOCK;

    mm_ctrl_pkg::rd_req_t   req;
    mm_ctrl_pkg::feed_tag_t rd_tag;
    mm_data_pkg::op_vec_t   a_rd;
    mm_data_pkg::op_vec_t   w_rd;

    mm_data_pkg::elem_t     a_feed [B];
    mm_ctrl_pkg::feed_tag_t t_feed [B];
    mm_data_pkg::elem_t     w_feed [B];

    // Mesh wires, column B and row B are the dangling edge outputs
    mm_data_pkg::elem_t     a_h [B][B+1];
    mm_ctrl_pkg::feed_tag_t t_h [B][B+1];
    mm_data_pkg::elem_t     w_v [B+1][B];
    logic                   cell_valid [B][B];
    mm_data_pkg::acc_t      cell_sum   [B][B];

    operand_buffer #(.ADDR_W(`MM_A_ADDR_W)) u_a_buf (
        .clk, .wr(a_wr), .wr_addr(a_addr), .wr_data(a_data),
        .rd_addr(req.a_addr), .rd_data(a_rd)
    );

    operand_buffer #(.ADDR_W(`MM_W_ADDR_W)) u_w_buf (
        .clk, .wr(w_wr), .wr_addr(w_addr), .wr_data(w_data),
        .rd_addr(req.w_addr), .rd_data(w_rd)
    );

    matmul_controller u_ctrl (
        .clk, .rst_n, .start, .done, .busy, .req, .tag(rd_tag)
    );

    systolic_feeder u_feed (
        .clk, .rst_n, .a_vec(a_rd), .w_vec(w_rd), .tag(rd_tag),
        .a_lane(a_feed), .a_tag(t_feed), .w_lane(w_feed)
    );

    for (genvar i = 0; i < B; i++) begin : g_edge
        assign a_h[i][0] = a_feed[i]; // Left edge
        assign t_h[i][0] = t_feed[i];
        assign w_v[0][i] = w_feed[i]; // Top edge
    end

    for (genvar i = 0; i < B; i++) begin : g_row
        for (genvar j = 0; j < B; j++) begin : g_col
            mac_cell u_cell (
                .clk, .rst_n,
                .a_in(a_h[i][j]), .w_in(w_v[i][j]), .tag_in(t_h[i][j]),
                .a_out(a_h[i][j+1]), .w_out(w_v[i+1][j]), .tag_out(t_h[i][j+1]),
                .sum_valid(cell_valid[i][j]), .sum(cell_sum[i][j])
            );
        end
    end

    systolic_drain u_drain (
        .clk, .rst_n, .sum_valid(cell_valid), .sum(cell_sum),
        .res_valid, .res, .done
    );

endmodule

// File: source/operand_buffer.sv
/* Simple dual-port RAM of operand vectors, read data one cycle after address
   Read and write to the same address in one cycle returns the old word */
`timescale 1ns/1ps

module operand_buffer #(
    parameter int ADDR_W = 3
) (
    input  logic                  clk,
    input  logic                  wr,
    input  logic [ADDR_W-1:0]     wr_addr,
    input  mm_data_pkg::op_vec_t  wr_data,
    input  logic [ADDR_W-1:0]     rd_addr,
    output mm_data_pkg::op_vec_t  rd_data
);

    mm_data_pkg::op_vec_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data; // Host load port
        end
        rd_data <= mem[rd_addr]; // Always reading, idle reads are masked later
    end

endmodule

// File: systolic/mac_cell.sv
/* Output-stationary processing element
   A slice tagged first restarts the sum, so tiles may follow back to back */
`timescale 1ns/1ps
`include "mm_consts.svh"

module mac_cell (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mm_data_pkg::elem_t     a_in,
    input  mm_data_pkg::elem_t     w_in,
    input  mm_ctrl_pkg::feed_tag_t tag_in,
    output mm_data_pkg::elem_t     a_out,     // To the right neighbour
    output mm_data_pkg::elem_t     w_out,     // To the cell below
    output mm_ctrl_pkg::feed_tag_t tag_out,
    output logic                   sum_valid,
    output mm_data_pkg::acc_t      sum
);

    logic signed [2*`MM_WIDTH-1:0] prod; // Q16.16
    mm_data_pkg::acc_t             acc;

    assign prod = a_in * w_in;
    assign sum  = acc; // Stable for the cycle of sum_valid

    always_ff @(posedge clk) begin
        if (tag_in.valid) begin
            acc <= tag_in.first ? mm_data_pkg::acc_t'(prod)
                                : acc + mm_data_pkg::acc_t'(prod);
        end
        a_out <= a_in;
        w_out <= w_in;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_out   <= '0;
            sum_valid <= 1'b0;
        end else begin
            tag_out   <= tag_in;
            sum_valid <= tag_in.valid && tag_in.last; // Sum final next cycle
        end
    end

    // Feeder and controller must never mark an empty slot
    a_tag_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (tag_in.first || tag_in.last) |-> tag_in.valid);

endmodule

// File: systolic/systolic_drain.sv
/* Collects tile sums, floors them to Q8.8 and saturates to 16 bits
   Next snapshot must not arrive before all BLOCK rows are out */
`timescale 1ns/1ps
`include "mm_consts.svh"

module systolic_drain (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sum_valid [`MM_BLOCK][`MM_BLOCK],
    input  mm_data_pkg::acc_t       sum       [`MM_BLOCK][`MM_BLOCK],
    output logic                    res_valid,
    output mm_data_pkg::res_row_t   res,
    output logic                    done
);

    localparam int B    = `MM_BLOCK;
    localparam int R_W  = (B > 1) ? $clog2(B) : 1;
    localparam int T_W  = (`MM_TILES > 1) ? $clog2(`MM_TILES) : 1;
    localparam mm_data_pkg::acc_t ELEM_MAX = mm_data_pkg::acc_t'(2 ** (`MM_WIDTH - 1) - 1);
    localparam mm_data_pkg::acc_t ELEM_MIN = -ELEM_MAX - 1;

    mm_data_pkg::acc_t     held [B][B]; // Earlier cells finish before the corner
    mm_data_pkg::acc_t     cur  [B][B];
    mm_data_pkg::res_row_t snap [B];
    logic                  snap_fire;
    logic                  emitting;
    logic                  last_row;
    logic                  last_tile;
    logic [R_W-1:0]        row_idx;
    logic [T_W-1:0]        tile_cnt;

    // Arithmetic shift floors, then clamp to the element range
    function automatic mm_data_pkg::elem_t scale_sat(mm_data_pkg::acc_t v);
        mm_data_pkg::acc_t s;
        s = v >>> `MM_FRAC;
        if (s > ELEM_MAX) begin
            return ELEM_MAX[`MM_WIDTH-1:0];
        end else if (s < ELEM_MIN) begin
            return ELEM_MIN[`MM_WIDTH-1:0];
        end
        return s[`MM_WIDTH-1:0];
    endfunction

    assign snap_fire = sum_valid[B-1][B-1]; // Bottom-right cell is always last
    assign last_row  = (row_idx == R_W'(B - 1));
    assign last_tile = (tile_cnt == T_W'(`MM_TILES - 1));

    always_comb begin
        for (int i = 0; i < B; i++) begin
            for (int j = 0; j < B; j++) begin
                cur[i][j] = sum_valid[i][j] ? sum[i][j] : held[i][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < B; i++) begin
            for (int j = 0; j < B; j++) begin
                if (sum_valid[i][j]) held[i][j] <= sum[i][j];
                if (snap_fire) snap[i].e[j] <= scale_sat(cur[i][j]);
            end
        end
    end

    // Row emission and tile count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            emitting <= 1'b0;
            row_idx  <= '0;
            tile_cnt <= '0;
        end else if (snap_fire) begin
            emitting <= 1'b1;
            row_idx  <= '0;
        end else if (emitting) begin
            row_idx <= last_row ? '0 : row_idx + 1'b1;
            if (last_row) begin
                emitting <= 1'b0;
                tile_cnt <= last_tile ? '0 : tile_cnt + 1'b1; // Wrap for next run
            end
        end
    end

    assign res_valid = emitting;
    assign res       = snap[row_idx]; // Top row first
    assign done      = emitting && last_row && last_tile;

    // Holds only while INNER >= 2*BLOCK keeps tiles apart in the array
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        snap_fire |-> !emitting);

endmodule

// File: systolic/systolic_feeder.sv
/* Skews the operand slice into a diagonal wavefront
   Lane i leaves i cycles after lane 0, tags travel with the A lanes only */
`timescale 1ns/1ps
`include "mm_consts.svh"

module systolic_feeder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mm_data_pkg::op_vec_t   a_vec,
    input  mm_data_pkg::op_vec_t   w_vec,
    input  mm_ctrl_pkg::feed_tag_t tag,
    output mm_data_pkg::elem_t     a_lane [`MM_BLOCK],
    output mm_ctrl_pkg::feed_tag_t a_tag  [`MM_BLOCK],
    output mm_data_pkg::elem_t     w_lane [`MM_BLOCK]
);

    for (genvar i = 0; i < `MM_BLOCK; i++) begin : g_lane
        // Stage 0 aligns all lanes, stages 1..i add the skew
        mm_data_pkg::elem_t     a_q [i+1];
        mm_data_pkg::elem_t     w_q [i+1];
        mm_ctrl_pkg::feed_tag_t t_q [i+1];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                t_q <= '{default: '0};
            end else begin
                t_q[0] <= tag;
                for (int d = 1; d <= i; d++) begin
                    t_q[d] <= t_q[d-1];
                end
            end
        end

        // Idle slots carry zero, stale RAM words never reach the array
        always_ff @(posedge clk) begin
            a_q[0] <= tag.valid ? a_vec.e[i] : '0;
            w_q[0] <= tag.valid ? w_vec.e[i] : '0;
            for (int d = 1; d <= i; d++) begin
                a_q[d] <= a_q[d-1];
                w_q[d] <= w_q[d-1];
            end
        end

        assign a_lane[i] = a_q[i]; // Into row i, column 0
        assign a_tag[i]  = t_q[i];
        assign w_lane[i] = w_q[i]; // Into column i, row 0
    end

endmodule

// File: verification/matmul_tb.sv
/* Directed testbench for matmul_top at the sizes in mm_consts.svh
   Identity test assumes INNER and W_OUTER describe a square W or wider */
`timescale 1ns/1ps
`include "mm_consts.svh"

module matmul_tb;

    localparam int B       = `MM_BLOCK;
    localparam int N_ROWS  = `MM_TILES * `MM_BLOCK; // Result rows per run
    localparam int A_AW    = `MM_A_ADDR_W;
    localparam int W_AW    = `MM_W_ADDR_W;
    localparam int TIMEOUT = 500;                   // Cycles allowed per run

    logic                  clk;
    logic                  rst_n;
    logic                  a_wr;
    logic [A_AW-1:0]       a_addr;
    mm_data_pkg::op_vec_t  a_data;
    logic                  w_wr;
    logic [W_AW-1:0]       w_addr;
    mm_data_pkg::op_vec_t  w_data;
    logic                  start;
    logic                  busy;
    logic                  res_valid;
    mm_data_pkg::res_row_t res;
    logic                  done;

    int a_m   [`MM_I_OUTER][`MM_INNER];  // Host copy of A
    int w_m   [`MM_INNER][`MM_W_OUTER];  // Host copy of W
    int c_exp [`MM_I_OUTER][`MM_W_OUTER];

    mm_data_pkg::res_row_t rows [$]; // Every row seen, never cleared
    int                    done_cnt = 0;
    logic [31:0]           rng_state;

    matmul_top UUT (
        .clk, .rst_n, .a_wr, .a_addr, .a_data, .w_wr, .w_addr, .w_data,
        .start, .busy, .res_valid, .res, .done
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Collector, outputs settle after posedge so negedge is safe
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            rows.push_back(res);
        end
        if (rst_n && done) begin
            done_cnt++;
        end
    end

    function automatic int next_rand(input int lo, input int hi);
        rng_state = rng_state ^ (rng_state << 13); // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return lo + int'(rng_state % 32'(hi - lo + 1));
    endfunction

    task automatic check_eq(input int got, input int exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Column k of each row tile is one A word
    task automatic load_a();
        for (int rt = 0; rt < `MM_ROW_TILES; rt++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                @(negedge clk);
                a_wr   = 1'b1;
                a_addr = A_AW'(rt * `MM_INNER + k);
                for (int l = 0; l < B; l++) begin
                    a_data.e[l] = mm_data_pkg::elem_t'(a_m[rt * B + l][k]);
                end
            end
        end
        @(negedge clk);
        a_wr = 1'b0;
    endtask

    // Row k of each column tile is one W word
    task automatic load_w();
        for (int ct = 0; ct < `MM_COL_TILES; ct++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                @(negedge clk);
                w_wr   = 1'b1;
                w_addr = W_AW'(ct * `MM_INNER + k);
                for (int l = 0; l < B; l++) begin
                    w_data.e[l] = mm_data_pkg::elem_t'(w_m[k][ct * B + l]);
                end
            end
        end
        @(negedge clk);
        w_wr = 1'b0;
    endtask

    task automatic fill_a(input int lo, input int hi);
        foreach (a_m[i, k]) a_m[i][k] = next_rand(lo, hi);
    endtask

    task automatic fill_w(input int lo, input int hi);
        foreach (w_m[k, j]) w_m[k][j] = next_rand(lo, hi);
    endtask

    // Integer sum, floor by shift, clamp to 16 bits
    task automatic compute_reference();
        longint acc;
        for (int i = 0; i < `MM_I_OUTER; i++) begin
            for (int j = 0; j < `MM_W_OUTER; j++) begin
                acc = 0;
                for (int k = 0; k < `MM_INNER; k++) begin
                    acc += longint'(a_m[i][k]) * longint'(w_m[k][j]);
                end
                acc = acc >>> `MM_FRAC;
                if (acc > 32767) acc = 32767;
                if (acc < -32768) acc = -32768;
                c_exp[i][j] = int'(acc);
            end
        end
    endtask

    task automatic wait_done(input int done_base);
        int n;
        n = 0;
        while (done_cnt == done_base) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: no done pulse within %0d cycles", TIMEOUT);
                $display("Result: FAILED");
                $fatal(1, "run stalled");
            end
        end
    endtask

    // busy is sampled mid-cycle, away from its update
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > 8) begin
                $display("Timeout: busy stayed high after the done pulse");
                $display("Result: FAILED");
                $fatal(1, "busy stuck");
            end
        end
    endtask

    // One run, optionally with a stray start while busy
    task automatic run_and_check(input string name, input bit poke_busy);
        int row_base;
        int done_base;
        int idx;
        row_base  = rows.size();
        done_base = done_cnt;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_eq(int'(busy), 1, {name, ": busy after start"});
        if (poke_busy) begin
            repeat (3) @(negedge clk);
            start = 1'b1; // Must be ignored
            @(negedge clk);
            start = 1'b0;
        end
        wait_done(done_base);
        wait_idle();
        repeat (4) @(posedge clk); // Nothing may trail the done pulse
        check_eq(done_cnt - done_base, 1, {name, ": done pulses"});
        check_eq(rows.size() - row_base, N_ROWS, {name, ": result rows"});
        for (int t = 0; t < `MM_TILES; t++) begin
            for (int r = 0; r < B; r++) begin
                idx = row_base + t * B + r; // Row-major tiles, top row first
                for (int j = 0; j < B; j++) begin
                    check_eq(int'(rows[idx].e[j]),
                             c_exp[(t / `MM_COL_TILES) * B + r][(t % `MM_COL_TILES) * B + j],
                             $sformatf("%s tile %0d row %0d col %0d", name, t, r, j));
                end
            end
        end
    endtask

    task automatic test_reset_quiet();
        repeat (10) begin
            @(negedge clk);
            check_eq(int'(busy), 0, "idle: busy");
            check_eq(int'(res_valid), 0, "idle: res_valid");
            check_eq(int'(done), 0, "idle: done");
        end
    endtask

    task automatic test_identity();
        fill_a(-32768, 32767);
        foreach (w_m[k, j]) w_m[k][j] = (k == j) ? 256 : 0; // 1.0 on diagonal
        foreach (c_exp[i, j]) c_exp[i][j] = (j < `MM_INNER) ? a_m[i][j] : 0;
        load_a();
        load_w();
        run_and_check("identity", 1'b0);
    endtask

    task automatic test_random_small();
        fill_a(-512, 511); // Within +-2.0, no saturation
        fill_w(-512, 511);
        load_a();
        load_w();
        compute_reference();
        run_and_check("random", 1'b0);
    endtask

    task automatic test_saturation();
        foreach (a_m[i, k]) a_m[i][k] = 32512;                     // 127.0
        foreach (w_m[k, j]) w_m[k][j] = (j % 2 == 0) ? 32512 : -32512;
        compute_reference();
        check_eq(c_exp[0][0], 32767, "model: positive clamp");
        check_eq(c_exp[0][1], -32768, "model: negative clamp");
        load_a();
        load_w();
        run_and_check("saturation", 1'b0);
    endtask

    task automatic test_busy_start_and_rerun();
        fill_a(-1024, 1023);
        fill_w(-1024, 1023);
        load_a();
        load_w();
        compute_reference();
        run_and_check("busy start", 1'b1);
        fill_w(-1024, 1023); // A stays in its buffer
        load_w();
        compute_reference();
        run_and_check("rerun new W", 1'b0);
    endtask

    initial begin
        rng_state = 32'd288;
        rst_n     = 1'b0;
        a_wr      = 1'b0;
        a_addr    = '0;
        a_data    = '0;
        w_wr      = 1'b0;
        w_addr    = '0;
        w_data    = '0;
        start     = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        test_reset_quiet();
        test_identity();
        test_random_small();
        test_saturation();
        test_busy_start_and_rerun();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/mm_data_pkg.sv
common/mm_ctrl_pkg.sv
source/operand_buffer.sv
source/matmul_controller.sv
systolic/systolic_feeder.sv
systolic/mac_cell.sv
systolic/systolic_drain.sv
source/matmul_top.sv
verification/matmul_tb.sv
